// File: common/dcache_pkg.sv
package dcache_pkg;

   typedef logic [31:0] word_t;

   // byte offset inside a two-word block, bit 2 picks the word
   localparam int WORD_OFFSET_BITS = 3;
   localparam int WAYS = 2;

   // set index field carried by store writes, wide enough for any legal NUM_SETS
   localparam int MAX_SET_BITS = 16;
   typedef logic [MAX_SET_BITS-1:0] set_idx_t;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_LOAD,
      OP_STORE
   } cpu_op_t;

   typedef enum logic [3:0] {
      IDLE,
      WB1,
      WB2,
      READ1,
      READ2,
      FLUSH_SCAN,
      FLUSH1,
      FLUSH2,
      HALTED
   } cache_state_t;

   typedef struct packed {
      cpu_op_t op;
      word_t   addr;
      word_t   data;
   } cpu_req_t;

   typedef struct packed {
      logic  dren;
      logic  dwen;
      word_t daddr;
      word_t dstore;
   } mem_req_t;

   // tag keeps the address bits above index and offset, the rest are zero
   typedef struct packed {
      word_t tag;
      logic  valid;
      logic  dirty;
      word_t word0;
      word_t word1;
   } way_line_t;

   // lru names the way used least recently
   typedef struct packed {
      way_line_t [WAYS-1:0] way;
      logic                 lru;
   } set_view_t;

   typedef struct packed {
      logic     en;
      set_idx_t set;
      logic     way;
      logic     word_sel;
      word_t    data;
      logic     write_data;
      logic     set_tag;
      word_t    tag;
      logic     set_valid;
      logic     set_dirty;
      logic     clr_dirty;
      logic     touch_lru;
   } store_wr_t;

   // clear index and offset bits, leaving the tag in place
   function automatic word_t addr_tag(word_t addr, int unsigned idx_bits);
      word_t mask;
      mask = '1;
      mask = mask << (idx_bits + WORD_OFFSET_BITS);
      return addr & mask;
   endfunction

   // memory word address of one word of a block
   function automatic word_t block_addr(word_t tag, word_t set_idx, logic word_sel);
      return tag | (set_idx << WORD_OFFSET_BITS) | {29'd0, word_sel, 2'b00};
   endfunction

endpackage

// File: dcache/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup
   import dcache_pkg::*;
#(
   parameter int NUM_SETS = 8
)
(
   input  word_t     addr,
   input  set_view_t view,
   output logic      hit,
   output logic      hit_way,
   output logic      victim_way,
   output logic      victim_dirty,
   output word_t     victim_tag,
   output word_t     load_word
);

   localparam int IDX_BITS = $clog2(NUM_SETS);

   word_t           req_tag;
   logic [WAYS-1:0] way_match;
   way_line_t       hit_line;
   way_line_t       victim_line;

   assign req_tag = addr_tag(addr, IDX_BITS);

   // tag compare on both ways, invalid lines never match
   always_comb
   begin
      for (int w = 0; w < WAYS; w++)
      begin
         way_match[w] = view.way[w].valid && (view.way[w].tag == req_tag);
      end
   end

   assign hit = |way_match;

   // way 1 only when it matched, otherwise way 0
   assign hit_way = way_match[1];
   assign hit_line = view.way[hit_way];

   // word select by address bit 2
   always_comb
   begin
      if (addr[2] == 1'b0)
      begin
         load_word = hit_line.word0;
      end
      else
      begin
         load_word = hit_line.word1;
      end
   end

   // victim is the least recently used way of the set
   assign victim_way = view.lru;
   assign victim_line = view.way[victim_way];
   assign victim_dirty = victim_line.valid && victim_line.dirty;
   assign victim_tag = victim_line.tag;

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
   import dcache_pkg::*;
#(
   parameter int NUM_SETS = 8
)
(
   input  logic                        CLK,
   input  logic                        nRST,
   input  cpu_req_t                    cpu_req,
   input  logic                        halt,
   input  logic                        hit,
   input  logic                        hit_way,
   input  logic                        victim_way,
   input  logic                        victim_dirty,
   input  word_t                       victim_tag,
   input  set_view_t                   view,
   input  logic                        dwait,
   input  word_t                       dload,
   output logic [$clog2(NUM_SETS)-1:0] rd_set,
   output store_wr_t                   store_wr,
   output mem_req_t                    mem,
   output logic                        dhit,
   output logic                        flushed
);

   localparam int IDX_BITS = $clog2(NUM_SETS);

   cache_state_t        state, next_state;
   logic [IDX_BITS:0]   scan, next_scan;
   logic [IDX_BITS-1:0] req_set;
   logic [IDX_BITS-1:0] scan_set;
   logic                scan_way;
   logic                scan_last;
   logic                flushing;
   logic                req_valid;
   way_line_t           victim_line;
   way_line_t           scan_line;

   assign req_set = cpu_req.addr[WORD_OFFSET_BITS +: IDX_BITS];
   assign req_valid = cpu_req.op != OP_NONE;

   // scan order is way 0 of every set, then way 1
   assign scan_set = scan[IDX_BITS-1:0];
   assign scan_way = scan[IDX_BITS];
   assign scan_last = &scan;

   assign flushing = state inside {FLUSH_SCAN, FLUSH1, FLUSH2};
   assign rd_set = flushing ? scan_set : req_set;

   assign victim_line = view.way[victim_way];
   assign scan_line = view.way[scan_way];

   assign dhit = (state == IDLE) && !halt && req_valid && hit;
   assign flushed = state == HALTED;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         state <= IDLE;
         scan <= '0;
      end
      else
      begin
         state <= next_state;
         scan <= next_scan;
      end
   end

   always_comb
   begin
      next_state = state;
      next_scan = scan;
      case (state)
         IDLE:
         begin
            if (halt)
            begin
               next_state = FLUSH_SCAN;
               next_scan = '0;
            end
            else if (req_valid && !hit)
            begin
               next_state = victim_dirty ? WB1 : READ1;
            end
         end
         WB1:    if (!dwait) next_state = WB2;
         WB2:    if (!dwait) next_state = READ1;
         READ1:  if (!dwait) next_state = READ2;
         READ2:  if (!dwait) next_state = IDLE;
         FLUSH_SCAN:
         begin
            if (scan_line.valid && scan_line.dirty)
            begin
               next_state = FLUSH1;
            end
            else if (scan_last)
            begin
               next_state = HALTED;
            end
            else
            begin
               next_scan = scan + 1'b1;
            end
         end
         FLUSH1: if (!dwait) next_state = FLUSH2;
         FLUSH2:
         begin
            if (!dwait)
            begin
               next_state = scan_last ? HALTED : FLUSH_SCAN;
               next_scan = scan_last ? scan : scan + 1'b1;
            end
         end
         HALTED: next_state = HALTED;
         default: next_state = IDLE;
      endcase
   end

   // memory request and block store write for the current state
   always_comb
   begin
      mem = '0;
      store_wr = '0;
      store_wr.set = set_idx_t'(rd_set);
      case (state)
         IDLE:
         begin
            // a load hit only refreshes LRU, a store also writes and dirties
            store_wr.en = dhit;
            store_wr.way = hit_way;
            store_wr.word_sel = cpu_req.addr[2];
            store_wr.data = cpu_req.data;
            store_wr.write_data = cpu_req.op == OP_STORE;
            store_wr.set_dirty = cpu_req.op == OP_STORE;
            store_wr.touch_lru = 1'b1;
         end
         WB1, WB2:
         begin
            mem.dwen = 1'b1;
            mem.daddr = block_addr(victim_tag, word_t'(req_set), state == WB2);
            mem.dstore = (state == WB2) ? victim_line.word1 : victim_line.word0;
         end
         READ1, READ2:
         begin
            mem.dren = 1'b1;
            mem.daddr = block_addr(addr_tag(cpu_req.addr, IDX_BITS), word_t'(req_set),
                                   state == READ2);
            store_wr.en = !dwait;
            store_wr.way = victim_way;
            store_wr.word_sel = state == READ2;
            store_wr.data = dload;
            store_wr.write_data = 1'b1;
            // second word completes the block
            if (state == READ2)
            begin
               store_wr.set_tag = 1'b1;
               store_wr.tag = addr_tag(cpu_req.addr, IDX_BITS);
               store_wr.set_valid = 1'b1;
               store_wr.clr_dirty = 1'b1;
               store_wr.touch_lru = 1'b1;
            end
         end
         FLUSH1, FLUSH2:
         begin
            mem.dwen = 1'b1;
            mem.daddr = block_addr(scan_line.tag, word_t'(scan_set), state == FLUSH2);
            mem.dstore = (state == FLUSH2) ? scan_line.word1 : scan_line.word0;
            store_wr.en = (state == FLUSH2) && !dwait;
            store_wr.way = scan_way;
            store_wr.clr_dirty = 1'b1;
         end
         default:
         begin
            mem = '0;
         end
      endcase
   end

   assert property (@(posedge CLK) disable iff (!nRST) !(mem.dren && mem.dwen));

   // halted is terminal until reset
   assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed);

endmodule

// File: dcache/dcache_store.sv
`timescale 1ns/1ps

module dcache_store
   import dcache_pkg::*;
#(
   parameter int NUM_SETS = 8
)
(
   input  logic                        CLK,
   input  logic                        nRST,
   input  logic [$clog2(NUM_SETS)-1:0] rd_set,
   input  store_wr_t                   store_wr,
   output set_view_t                   view
);

   localparam int IDX_BITS = $clog2(NUM_SETS);

   word_t               tag_q   [NUM_SETS][WAYS];
   word_t               word0_q [NUM_SETS][WAYS];
   word_t               word1_q [NUM_SETS][WAYS];
   logic [WAYS-1:0]     valid_q [NUM_SETS];
   logic [WAYS-1:0]     dirty_q [NUM_SETS];
   logic [NUM_SETS-1:0] lru_q;
   logic [IDX_BITS-1:0] wr_set;

   assign wr_set = store_wr.set[IDX_BITS-1:0];

   // line state and LRU
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            valid_q[s] <= '0;
            dirty_q[s] <= '0;
         end
         lru_q <= '0;
      end
      else if (store_wr.en)
      begin
         if (store_wr.set_valid)
         begin
            valid_q[wr_set][store_wr.way] <= 1'b1;
         end
         if (store_wr.set_dirty)
         begin
            dirty_q[wr_set][store_wr.way] <= 1'b1;
         end
         else if (store_wr.clr_dirty)
         begin
            dirty_q[wr_set][store_wr.way] <= 1'b0;
         end
         // the other way becomes least recently used
         if (store_wr.touch_lru)
         begin
            lru_q[wr_set] <= ~store_wr.way;
         end
      end
   end

   // tags and data words
   always_ff @(posedge CLK)
   begin
      if (store_wr.en)
      begin
         if (store_wr.set_tag)
         begin
            tag_q[wr_set][store_wr.way] <= store_wr.tag;
         end
         if (store_wr.write_data && store_wr.word_sel)
         begin
            word1_q[wr_set][store_wr.way] <= store_wr.data;
         end
         else if (store_wr.write_data)
         begin
            word0_q[wr_set][store_wr.way] <= store_wr.data;
         end
      end
   end

   always_comb
   begin
      for (int w = 0; w < WAYS; w++)
      begin
         view.way[w].tag = tag_q[rd_set][w];
         view.way[w].valid = valid_q[rd_set][w];
         view.way[w].dirty = dirty_q[rd_set][w];
         view.way[w].word0 = word0_q[rd_set][w];
         view.way[w].word1 = word1_q[rd_set][w];
      end
      view.lru = lru_q[rd_set];
   end

   assert property (@(posedge CLK) disable iff (!nRST) store_wr.en |-> store_wr.set < NUM_SETS);

endmodule

// File: dcache/dcache.sv
`timescale 1ns/1ps

module dcache
   import dcache_pkg::*;
#(
   parameter int NUM_SETS = 8
)
(
   input  logic     CLK,
   input  logic     nRST,
   input  cpu_req_t cpu_req,
   input  logic     halt,
   input  logic     dwait,
   input  word_t    dload,
   output mem_req_t mem,
   output logic     dhit,
   output word_t    dmemload,
   output logic     flushed
);

   logic [$clog2(NUM_SETS)-1:0] rd_set;
   store_wr_t                   store_wr;
   set_view_t                   view;
   logic                        hit;
   logic                        hit_way;
   logic                        victim_way;
   logic                        victim_dirty;
   word_t                       victim_tag;

   // lookup on the set addressed by the controller
   dcache_lookup #(
      .NUM_SETS(NUM_SETS)
   ) i_lookup (
      .addr        (cpu_req.addr),
      .view        (view),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way),
      .victim_dirty(victim_dirty),
      .victim_tag  (victim_tag),
      .load_word   (dmemload)
   );

   dcache_ctrl #(
      .NUM_SETS(NUM_SETS)
   ) i_ctrl (
      .CLK         (CLK),
      .nRST        (nRST),
      .cpu_req     (cpu_req),
      .halt        (halt),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way),
      .victim_dirty(victim_dirty),
      .victim_tag  (victim_tag),
      .view        (view),
      .dwait       (dwait),
      .dload       (dload),
      .rd_set      (rd_set),
      .store_wr    (store_wr),
      .mem         (mem),
      .dhit        (dhit),
      .flushed     (flushed)
   );

   dcache_store #(
      .NUM_SETS(NUM_SETS)
   ) i_store (
      .CLK     (CLK),
      .nRST    (nRST),
      .rd_set  (rd_set),
      .store_wr(store_wr),
      .view    (view)
   );

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 8;
   localparam int MAX_LINES = 64;
   localparam int MEM_WORDS = 1024;
   localparam int CYCLES_PER_LINE = 40;

   logic     CLK;
   logic     nRST;
   cpu_req_t cpu_req;
   logic     halt;
   logic     dwait;
   word_t    dload;
   mem_req_t mem;
   logic     dhit;
   word_t    dmemload;
   logic     flushed;

   word_t       stim [0:MAX_LINES*4-1];
   word_t       mem_words [0:MEM_WORDS-1];
   int          stim_lines;
   int          checks;
   int          value_errors;
   int          other_errors;
   logic [31:0] rng;
   logic        busy;
   logic [1:0]  wait_left;
   logic        prev_wr_valid;
   word_t       prev_wr_addr;

   dcache #(
      .NUM_SETS(8)
   ) i_dcache (
      .CLK     (CLK),
      .nRST    (nRST),
      .cpu_req (cpu_req),
      .halt    (halt),
      .dwait   (dwait),
      .dload   (dload),
      .mem     (mem),
      .dhit    (dhit),
      .dmemload(dmemload),
      .flushed (flushed)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // one word transfer that completes at the next rising edge
   task automatic serve_transfer();
      int idx;
      idx = mem.daddr[31:2];
      if (mem.daddr >= MEM_WORDS * 4)
      begin
         other_errors++;
         $display("memory access to %h lies outside the memory model", mem.daddr);
      end
      else if (mem.dren)
      begin
         dload = mem_words[idx];
         prev_wr_valid = 1'b0;
      end
      else
      begin
         // word 1 of a block must directly follow word 0
         if (mem.daddr[2] && !(prev_wr_valid && prev_wr_addr == mem.daddr - 32'd4))
         begin
            other_errors++;
            $display("write to %h at %0t ns was not preceded by word 0 of its block",
                     mem.daddr, $time);
         end
         prev_wr_valid = !mem.daddr[2];
         prev_wr_addr = mem.daddr;
         mem_words[idx] = mem.dstore;
      end
   endtask

   // memory model with random wait cycles per transfer
   always @(negedge CLK)
   begin
      if (nRST == 1'b0)
      begin
         dwait = 1'b1;
         busy = 1'b0;
      end
      else
      begin
         if (dwait == 1'b0)
         begin
            busy = 1'b0;
         end
         dwait = 1'b1;
         if (mem.dren && mem.dwen)
         begin
            other_errors++;
            $display("memory read and write requested together at %0t ns", $time);
         end
         else if (mem.dren || mem.dwen)
         begin
            if (!busy)
            begin
               busy = 1'b1;
               rng = lcg_next(rng);
               wait_left = rng[17:16];
            end
            if (wait_left == 2'd0)
            begin
               dwait = 1'b0;
               serve_transfer();
            end
            else
            begin
               wait_left = wait_left - 2'd1;
            end
         end
      end
   end

   // hold one request until dhit and then check a load result
   task automatic run_request(input word_t op_code, input word_t addr, input word_t data,
                              input word_t expected);
      logic  got;
      word_t load_val;
      got = 1'b0;
      load_val = '0;
      @(negedge CLK);
      cpu_req.op = (op_code == 32'd1) ? OP_LOAD : OP_STORE;
      cpu_req.addr = addr;
      cpu_req.data = data;
      while (!got)
      begin
         @(posedge CLK);
         if (dhit)
         begin
            got = 1'b1;
            load_val = dmemload;
            // the memory model still counts a started transfer as open
            if (busy || mem.dren || mem.dwen)
            begin
               other_errors++;
               $display("request to %h answered while a memory transfer was open", addr);
            end
         end
      end
      if (op_code == 32'd1)
      begin
         checks++;
         if (load_val != expected)
         begin
            value_errors++;
            $display("[FAIL] %0t ns: load of %h returned %h, expected %h",
                     $time, addr, load_val, expected);
         end
      end
      @(negedge CLK);
      cpu_req = '0;
   endtask

   initial
   begin
      int line;
      CLK = 1'b0;
      nRST = 1'b0;
      halt = 1'b0;
      cpu_req = '0;
      dwait = 1'b1;
      dload = '0;
      rng = 32'h30616549;
      busy = 1'b0;
      wait_left = '0;
      prev_wr_valid = 1'b0;
      prev_wr_addr = '0;
      checks = 0;
      value_errors = 0;
      other_errors = 0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem_words[i] = (i << 2) ^ 32'hA5A5_0000;
      end
      for (int i = 0; i < MAX_LINES * 4; i++)
      begin
         stim[i] = '0;
      end
      $readmemh("dv/dcache_stimulus.txt", stim);
      stim_lines = 0;
      while (stim_lines < MAX_LINES && stim[stim_lines*4] != 32'd0)
      begin
         stim_lines++;
      end
      if (stim_lines == 0)
      begin
         other_errors++;
         $display("stimulus file is missing or holds no operations");
      end
      repeat (RESET_CYCLES) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;

      line = 0;
      while (line < stim_lines && stim[line*4] != 32'd3)
      begin
         if (stim[line*4] == 32'd1 || stim[line*4] == 32'd2)
         begin
            run_request(stim[line*4], stim[line*4+1], stim[line*4+2], stim[line*4+3]);
         end
         else
         begin
            other_errors++;
            $display("unknown operation code %h on stimulus line %0d", stim[line*4], line);
         end
         line++;
      end

      // halt flush and then flushed must stay high
      if (line < stim_lines)
      begin
         @(negedge CLK);
         halt = 1'b1;
         while (!flushed)
         begin
            @(posedge CLK);
         end
         repeat (4)
         begin
            @(posedge CLK);
            if (!flushed)
            begin
               other_errors++;
               $display("flushed dropped at %0t ns after it had risen", $time);
            end
         end
         line++;
      end

      // memory contents after the flush
      while (line < stim_lines && stim[line*4] == 32'd4)
      begin
         checks++;
         if (mem_words[stim[line*4+1][31:2]] != stim[line*4+3])
         begin
            value_errors++;
            $display("[FAIL] %0t ns: memory word %h holds %h, expected %h", $time,
                     stim[line*4+1], mem_words[stim[line*4+1][31:2]], stim[line*4+3]);
         end
         line++;
      end

      $display("summary: %0d checks, %0d value errors, %0d other errors",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

   // watchdog scaled by the number of stimulus lines
   initial
   begin
      wait (stim_lines > 0);
      #((stim_lines * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
      $display("timeout: the cache did not finish the stimulus in time");
      $display("test failed");
      $finish;
   end

endmodule

// File: dv/dcache_stimulus.txt
// columns: op addr store_data expected
// op 1 load, 2 store, 3 halt and flush, 4 memory word check after the flush
1 00000000 00000000 a5a50000
1 00000004 00000000 a5a50004
2 00000010 11111111 00000000
1 00000014 00000000 a5a50014
2 00000054 22222222 00000000
1 00000010 00000000 11111111
1 00000090 00000000 a5a50090
1 00000054 00000000 22222222
1 00000050 00000000 a5a50050
2 00000094 33333333 00000000
2 00000018 44444444 00000000
2 000000d0 55555555 00000000
1 000000d0 00000000 55555555
1 00000094 00000000 33333333
2 000003fc 66666666 00000000
1 000003f8 00000000 a5a503f8
3 00000000 00000000 00000000
4 00000010 00000000 11111111
4 00000014 00000000 a5a50014
4 00000054 00000000 22222222
4 00000094 00000000 33333333
4 00000018 00000000 44444444
4 000000d0 00000000 55555555
4 000003fc 00000000 66666666
4 00000000 00000000 a5a50000

// File: all.f
common/dcache_pkg.sv
dcache/dcache_lookup.sv
dcache/dcache_ctrl.sv
dcache/dcache_store.sv
dcache/dcache.sv
dv/dcache_tb.sv
